// ==== Makefile ====
SRCS := $(shell cat rob_sys.f)

all: obj_dir/Vtb_rob_top

obj_dir/Vtb_rob_top: rob_sys.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rob_top -f rob_sys.f

run: obj_dir/Vtb_rob_top
	obj_dir/Vtb_rob_top > sim.log 2>&1; cat sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

// ==== rob_sys.f ====
src/rob_pkg.sv
src/dispatch_unit.sv
src/reorder_buffer.sv
src/commit_unit.sv
src/rob_top.sv
testbench/tb_rob_top.sv

// ==== src/commit_unit.sv ====
// Retires one entry per cycle and predicts every jump to fall through to its address plus 4
`timescale 1ns/1ps

module commit_unit
  import rob_pkg::*;
(
  input  logic        cs,
  input  logic        i_reset,
  input  head_t       i_head,
  output logic        o_head_take,
  output commit_t     o_commit,
  output spec_ctrl_t  o_spec,
  output logic        o_redirect_valid,
  output logic [31:0] o_redirect_address
);

  logic [31:0] next_address;
  logic        is_jump;
  logic        fall_through;

  // Every completed head is taken at once
  assign o_head_take = i_head.valid;

  assign next_address = i_head.address + 32'd4;
  assign is_jump      = i_head.valid && i_head.flags.jumps;
  // Target equal to the sequential address confirms the guess
  assign fall_through = i_head.target == next_address;

  always_ff @(posedge cs) begin
    if (i_reset) begin
      o_commit.valid    <= 1'b0;
      o_spec            <= '0;
      o_redirect_valid  <= 1'b0;
    end else begin
      o_commit.valid    <= i_head.valid;
      o_spec.clear_tag  <= is_jump && fall_through;
      o_spec.delete_tag <= is_jump && !fall_through;
      o_redirect_valid  <= is_jump && !fall_through;

      // Commit record
      if (i_head.valid) begin
        o_commit.address <= i_head.address;
        o_commit.rd      <= i_head.rd;
        o_commit.writes  <= i_head.flags.writes;
        o_commit.value   <= i_head.result;
      end

      // Fetch target for a wrong guess
      if (is_jump) begin
        o_redirect_address <= i_head.target;
      end
    end
  end

  // A jump resolves one way only
  a_spec_exclusive: assert property (@(posedge cs) disable iff (i_reset)
    !(o_spec.clear_tag && o_spec.delete_tag));

  // Buffer withholds its head during the flush cycle
  a_flush_gap: assert property (@(posedge cs) disable iff (i_reset)
    o_spec.delete_tag |-> !o_head_take);

endmodule

// ==== src/dispatch_unit.sv ====
// The tag flag on i_instr is ignored and restamped, and a pair may carry at most one jump
`timescale 1ns/1ps

module dispatch_unit
  import rob_pkg::*;
(
  input  logic                      cs,
  input  logic                      i_reset,
  input  instr_t [1:0]              i_instr,
  input  logic                      i_full,
  input  spec_ctrl_t                i_spec,
  output logic                      o_ready,
  output logic [ROB_INDEX_BITS-1:0] o_alloc_index,
  output issue_pair_t               o_issue
);

  logic [ROB_INDEX_BITS-1:0] alloc_ptr_q;
  logic                      jump_pending_q;
  logic                      started_q;
  logic                      pending;
  logic                      pair_jumps;
  logic                      accept;
  issue_pair_t               stamped;

  // Speculation ends in the cycle its resolution pulse arrives
  assign pending = jump_pending_q && !i_spec.clear_tag && !i_spec.delete_tag;

  assign pair_jumps = (i_instr[0].valid && i_instr[0].flags.jumps) ||
                      (i_instr[1].valid && i_instr[1].flags.jumps);

  // Stall on a full buffer, on a flush, and on a second jump level
  assign o_ready = started_q && !i_full && !i_spec.delete_tag && !(pending && pair_jumps);

  assign accept        = o_ready && i_instr[0].valid;
  assign o_alloc_index = alloc_ptr_q;

  // Index and tag stamping of the incoming pair
  always_comb begin
    stamped.slot[0].instr           = i_instr[0];
    stamped.slot[0].index           = alloc_ptr_q;
    stamped.slot[0].instr.flags.tag = pending;
    stamped.slot[1].instr           = i_instr[1];
    stamped.slot[1].index           = alloc_ptr_q + ROB_INDEX_BITS'(1);
    // Younger than a jump in slot 0 as well
    stamped.slot[1].instr.flags.tag = pending || i_instr[0].flags.jumps;
  end

  always_ff @(posedge cs) begin
    if (i_reset) begin
      started_q                   <= 1'b0;
      alloc_ptr_q                 <= '0;
      jump_pending_q              <= 1'b0;
      o_issue.slot[0].instr.valid <= 1'b0;
      o_issue.slot[1].instr.valid <= 1'b0;
    end else begin
      started_q <= 1'b1;
      if (accept) begin
        o_issue        <= stamped;
        alloc_ptr_q    <= alloc_ptr_q +
                          (i_instr[1].valid ? ROB_INDEX_BITS'(2) : ROB_INDEX_BITS'(1));
        jump_pending_q <= pending || pair_jumps;
      end else begin
        o_issue.slot[0].instr.valid <= 1'b0;
        o_issue.slot[1].instr.valid <= 1'b0;
        jump_pending_q              <= pending;
      end
    end
  end

  // Slot 1 only travels together with slot 0
  a_slot_order: assert property (@(posedge cs) disable iff (i_reset)
    i_instr[1].valid |-> i_instr[0].valid);

  // Only one speculation level, so an accepted pair holds one jump at most
  a_one_jump: assert property (@(posedge cs) disable iff (i_reset)
    accept |-> !(i_instr[0].flags.jumps && i_instr[1].valid && i_instr[1].flags.jumps));

endmodule

// ==== src/reorder_buffer.sv ====
// Results are keyed by reorder index, and both result ports must not name one entry in a cycle
`timescale 1ns/1ps

module reorder_buffer
  import rob_pkg::*;
(
  input  logic          cs,
  input  logic          i_reset,
  input  issue_pair_t   i_issue,
  input  result_t [1:0] i_result,
  input  logic          i_head_take,
  input  spec_ctrl_t    i_spec,
  output head_t         o_head,
  output logic          o_full
);

  // Data part of a record, status and tag live in their own arrays
  typedef struct packed {
    logic [31:0] address;
    logic [4:0]  rd;
    logic        writes;
    logic        mem;
    logic        jumps;
    logic [31:0] result;
    logic [31:0] target;
  } payload_t;

  payload_t                  payload_q [ROB_DEPTH];
  record_status_e            status_q  [ROB_DEPTH];
  logic                      tag_q     [ROB_DEPTH];

  logic [ROB_INDEX_BITS-1:0] head_q;
  logic [ROB_INDEX_BITS:0]   count_q;
  logic [ROB_INDEX_BITS:0]   free_count;
  logic [1:0]                write_count;
  logic                      head_skip;
  logic                      head_advance;

  assign write_count = {1'b0, i_issue.slot[0].instr.valid} +
                       {1'b0, i_issue.slot[1].instr.valid};

  assign free_count = (ROB_INDEX_BITS + 1)'(ROB_DEPTH) - count_q;
  assign o_full     = free_count < (ROB_INDEX_BITS + 1)'(ROB_FREE_MIN);

  // Flushed entries leave the head one per cycle
  assign head_skip    = (count_q != '0) && (status_q[head_q] == IGNORE);
  assign head_advance = head_skip || i_head_take;

  // Head is held back while a flush is being applied
  always_comb begin
    o_head.valid        = (count_q != '0) && (status_q[head_q] == COMPLETED) &&
                          !i_spec.delete_tag;
    o_head.index        = head_q;
    o_head.address      = payload_q[head_q].address;
    o_head.rd           = payload_q[head_q].rd;
    o_head.flags.writes = payload_q[head_q].writes;
    o_head.flags.mem    = payload_q[head_q].mem;
    o_head.flags.jumps  = payload_q[head_q].jumps;
    o_head.flags.tag    = tag_q[head_q];
    o_head.result       = payload_q[head_q].result;
    o_head.target       = payload_q[head_q].target;
  end

  // Record data
  always_ff @(posedge cs) begin
    for (int p = 0; p < 2; p++) begin
      if (i_result[p].valid && status_q[i_result[p].index] == WAITING) begin
        payload_q[i_result[p].index].result <= i_result[p].value;
        payload_q[i_result[p].index].target <= i_result[p].target;
      end
    end
    for (int s = 0; s < 2; s++) begin
      if (i_issue.slot[s].instr.valid) begin
        payload_q[i_issue.slot[s].index].address <= i_issue.slot[s].instr.address;
        payload_q[i_issue.slot[s].index].rd      <= i_issue.slot[s].instr.rd;
        payload_q[i_issue.slot[s].index].writes  <= i_issue.slot[s].instr.flags.writes;
        payload_q[i_issue.slot[s].index].mem     <= i_issue.slot[s].instr.flags.mem;
        payload_q[i_issue.slot[s].index].jumps   <= i_issue.slot[s].instr.flags.jumps;
      end
    end
  end

  // Record status, tags and pointers
  always_ff @(posedge cs) begin
    if (i_reset) begin
      for (int e = 0; e < ROB_DEPTH; e++) begin
        status_q[e] <= IGNORE;
        tag_q[e]    <= 1'b0;
      end
      head_q  <= '0;
      count_q <= '0;
    end else begin
      // Late or stale results fall through here
      for (int p = 0; p < 2; p++) begin
        if (i_result[p].valid && status_q[i_result[p].index] == WAITING) begin
          status_q[i_result[p].index] <= COMPLETED;
        end
      end

      if (i_head_take) begin
        status_q[head_q] <= DONE;
      end

      // Either resolution drops every tag
      if (i_spec.delete_tag || i_spec.clear_tag) begin
        for (int e = 0; e < ROB_DEPTH; e++) begin
          if (i_spec.delete_tag && tag_q[e]) begin
            status_q[e] <= IGNORE;
          end
          tag_q[e] <= 1'b0;
        end
      end

      // New slots override anything above, the pair in flight sees the resolution too
      for (int s = 0; s < 2; s++) begin
        if (i_issue.slot[s].instr.valid) begin
          if (i_spec.delete_tag && i_issue.slot[s].instr.flags.tag) begin
            status_q[i_issue.slot[s].index] <= IGNORE;
          end else begin
            status_q[i_issue.slot[s].index] <= WAITING;
          end
          tag_q[i_issue.slot[s].index] <= i_issue.slot[s].instr.flags.tag &&
                                          !i_spec.clear_tag && !i_spec.delete_tag;
        end
      end

      if (head_advance) begin
        head_q <= head_q + ROB_INDEX_BITS'(1);
      end
      count_q <= count_q + (ROB_INDEX_BITS + 1)'(write_count) -
                 (ROB_INDEX_BITS + 1)'(head_advance);
    end
  end

  // Dispatch back-pressure leaves room for every slot it sends
  a_no_overflow: assert property (@(posedge cs) disable iff (i_reset)
    i_issue.slot[0].instr.valid |-> free_count >= (ROB_INDEX_BITS + 1)'(write_count));

  // The commit side only takes a completed head
  a_take_valid: assert property (@(posedge cs) disable iff (i_reset)
    i_head_take |-> o_head.valid);

endmodule

// ==== src/rob_pkg.sv ====
// ROB_DEPTH must equal 2**ROB_INDEX_BITS because reorder indices wrap with the pointer width
package rob_pkg;

  // Buffer geometry
  localparam int ROB_INDEX_BITS = 5;
  localparam int ROB_DEPTH      = 32;
  // Room for the pair in the dispatch register plus one new pair
  localparam int ROB_FREE_MIN   = 4;

  typedef enum logic [2:0] {
    WAITING,
    COMPLETED,
    IGNORE,
    DONE
  } record_status_e;

  typedef struct packed {
    logic writes;
    logic mem;
    logic jumps;
    logic tag;
  } instr_flags_t;

  typedef struct packed {
    logic         valid;
    logic [31:0]  address;
    logic [4:0]   rd;
    instr_flags_t flags;
  } instr_t;

  typedef struct packed {
    instr_t                    instr;
    logic [ROB_INDEX_BITS-1:0] index;
  } issue_slot_t;

  // Slot 0 is the older instruction of the pair
  typedef struct packed {
    issue_slot_t [1:0] slot;
  } issue_pair_t;

  typedef struct packed {
    logic                      valid;
    logic [ROB_INDEX_BITS-1:0] index;
    logic [31:0]               value;
    logic [31:0]               target;
  } result_t;

  typedef struct packed {
    logic                      valid;
    logic [ROB_INDEX_BITS-1:0] index;
    logic [31:0]               address;
    logic [4:0]                rd;
    instr_flags_t              flags;
    logic [31:0]               result;
    logic [31:0]               target;
  } head_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] address;
    logic [4:0]  rd;
    logic        writes;
    logic [31:0] value;
  } commit_t;

  // Jump resolution pulses from the commit side
  typedef struct packed {
    logic clear_tag;
    logic delete_tag;
  } spec_ctrl_t;

endpackage

// ==== src/rob_top.sv ====
// Stimulus keeps slot 1 invalid without slot 0 and completes only entries already in the buffer
`timescale 1ns/1ps

module rob_top
  import rob_pkg::*;
(
  input  logic                      cs,
  input  logic                      i_reset,
  input  instr_t [1:0]              i_instr,
  input  result_t [1:0]             i_result,
  output logic                      o_ready,
  output logic [ROB_INDEX_BITS-1:0] o_alloc_index,
  output commit_t                   o_commit,
  output logic                      o_redirect_valid,
  output logic [31:0]               o_redirect_address
);

  issue_pair_t issue;
  logic        full;
  head_t       head;
  logic        head_take;
  spec_ctrl_t  spec;

  dispatch_unit u_dispatch (
    .cs            (cs),
    .i_reset       (i_reset),
    .i_instr       (i_instr),
    .i_full        (full),
    .i_spec        (spec),
    .o_ready       (o_ready),
    .o_alloc_index (o_alloc_index),
    .o_issue       (issue)
  );

  reorder_buffer u_rob (
    .cs          (cs),
    .i_reset     (i_reset),
    .i_issue     (issue),
    .i_result    (i_result),
    .i_head_take (head_take),
    .i_spec      (spec),
    .o_head      (head),
    .o_full      (full)
  );

  commit_unit u_commit (
    .cs                 (cs),
    .i_reset            (i_reset),
    .i_head             (head),
    .o_head_take        (head_take),
    .o_commit           (o_commit),
    .o_spec             (spec),
    .o_redirect_valid   (o_redirect_valid),
    .o_redirect_address (o_redirect_address)
  );

endmodule

// ==== testbench/tb_rob_top.sv ====
// Unaccepted pairs are held on i_instr, and results go only to entries two cycles past acceptance
`timescale 1ns/1ps

module tb_rob_top
  import rob_pkg::*;
();

  localparam int RESET_CYCLES = 8;
  localparam int DRAIN_LIMIT  = 200;
  localparam int TEST_CYCLES  = 20 + 600 + 300 + 3 * 400 + 5 * (DRAIN_LIMIT + 5);
  localparam int WATCHDOG_NS  = (RESET_CYCLES + TEST_CYCLES) * 40 * 4;

  // One outstanding instruction in program order
  typedef struct packed {
    logic [ROB_INDEX_BITS-1:0] index;
    logic [31:0]               address;
    logic [4:0]                rd;
    logic                      writes;
    logic                      jumps;
    logic                      tag;
    logic                      completed;
    logic [31:0]               value;
    logic [31:0]               target;
    logic [31:0]               accept_cyc;
  } model_entry_t;

  logic                      cs = 1'b0;
  logic                      i_reset;
  instr_t [1:0]              i_instr;
  result_t [1:0]             i_result;
  logic                      o_ready;
  logic [ROB_INDEX_BITS-1:0] o_alloc_index;
  commit_t                   o_commit;
  logic                      o_redirect_valid;
  logic [31:0]               o_redirect_address;

  model_entry_t              model_q[$];
  logic [ROB_INDEX_BITS-1:0] next_index = '0;
  logic [31:0]               next_address = 32'h0000_1000;
  logic                      model_pending = 1'b0;
  logic                      held = 1'b0;
  logic                      ready_dropped = 1'b0;
  int                        cyc = 0;
  int                        errors = 0;
  int                        tests_failed = 0;
  int                        commits = 0;
  int                        redirects = 0;
  int                        stalls = 0;
  int                        accepted = 0;
  int                        mark;

  always #20 cs = ~cs;

  always @(posedge cs) cyc <= cyc + 1;

  rob_top dut_i (
    .cs                 (cs),
    .i_reset            (i_reset),
    .i_instr            (i_instr),
    .i_result           (i_result),
    .o_ready            (o_ready),
    .o_alloc_index      (o_alloc_index),
    .o_commit           (o_commit),
    .o_redirect_valid   (o_redirect_valid),
    .o_redirect_address (o_redirect_address)
  );

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests finished");
    $display("Errors found");
    $finish;
  end

  function automatic logic [31:0] jump_target(logic [31:0] address, int mode);
    logic fall;
    fall = (mode == 1) || (mode == 0 && $urandom_range(1) == 1);
    if (fall) begin
      return address + 32'd4;
    end
    return address + 32'd8 + 32'd4 * $urandom_range(63);
  endfunction

  task automatic drive_pair(int issue_pct, int jump_pct);
    instr_t [1:0] pair;
    int           jump_slot;
    if (issue_pct > 0 && held) begin
      return;
    end
    pair = '0;
    if (int'($urandom_range(99)) < issue_pct) begin
      for (int s = 0; s < 2; s++) begin
        if (s == 0 || $urandom_range(1) == 1) begin
          pair[s].valid        = 1'b1;
          pair[s].address      = next_address;
          pair[s].rd           = 5'($urandom);
          pair[s].flags.writes = 1'($urandom);
          pair[s].flags.mem    = 1'($urandom);
          next_address         = next_address + 32'd4;
        end
      end
      // At most one jump per pair
      if (int'($urandom_range(99)) < jump_pct) begin
        jump_slot = pair[1].valid ? int'($urandom_range(1)) : 0;
        pair[jump_slot].flags.jumps = 1'b1;
      end
    end
    i_instr = pair;
  endtask

  task automatic drive_results(int result_pct, int target_mode);
    int            cand[$];
    int            pick;
    model_entry_t  e;
    result_t [1:0] res;
    res = '0;
    for (int i = 0; i < model_q.size(); i++) begin
      if (!model_q[i].completed && cyc >= int'(model_q[i].accept_cyc) + 2) begin
        cand.push_back(i);
      end
    end
    for (int p = 0; p < 2; p++) begin
      if (cand.size() > 0 && int'($urandom_range(99)) < result_pct) begin
        pick        = int'($urandom_range(cand.size() - 1));
        e           = model_q[cand[pick]];
        e.completed = 1'b1;
        e.value     = $urandom;
        e.target    = e.jumps ? jump_target(e.address, target_mode) : $urandom;
        model_q[cand[pick]] = e;
        res[p].valid  = 1'b1;
        res[p].index  = e.index;
        res[p].value  = e.value;
        res[p].target = e.target;
        cand.delete(pick);
      end
    end
    i_result = res;
  endtask

  // Mid-cycle view of what the next rising edge will do
  task automatic check_cycle();
    model_entry_t e;
    model_entry_t t;
    logic         flush;
    logic         pair_jumps;
    e          = '0;
    flush      = 1'b0;
    pair_jumps = (i_instr[0].valid && i_instr[0].flags.jumps) ||
                 (i_instr[1].valid && i_instr[1].flags.jumps);
    if (o_redirect_valid) redirects++;
    if (o_commit.valid && model_q.size() == 0) begin
      $display("Commit of address %h at %0t with nothing outstanding", o_commit.address, $time);
      errors++;
    end else if (o_commit.valid) begin
      commits++;
      e = model_q.pop_front();
      if (!e.completed || o_commit.address != e.address || o_commit.rd != e.rd ||
          o_commit.writes != e.writes || o_commit.value != e.value) begin
        $display("[ERROR] %0t: commit %h rd %0d w %0b value %h, expected %h rd %0d w %0b value %h",
                 $time, o_commit.address, o_commit.rd, o_commit.writes, o_commit.value,
                 e.address, e.rd, e.writes, e.value);
        errors++;
      end
      // Jump resolution drops or confirms the tagged entries
      if (e.jumps) begin
        flush         = e.target != e.address + 32'd4;
        model_pending = 1'b0;
        for (int i = model_q.size() - 1; i >= 0; i--) begin
          if (model_q[i].tag && flush) begin
            model_q.delete(i);
          end else if (model_q[i].tag) begin
            t     = model_q[i];
            t.tag = 1'b0;
            model_q[i] = t;
          end
        end
      end
    end
    if (o_redirect_valid != flush || (flush && o_redirect_address != e.target)) begin
      $display("[ERROR] %0t: redirect %0b to %h, expected %0b to %h", $time,
               o_redirect_valid, o_redirect_address, flush, e.target);
      errors++;
    end
    if (o_alloc_index != next_index) begin
      $display("[ERROR] %0t: alloc index %0d, expected %0d", $time, o_alloc_index, next_index);
      errors++;
    end
    if (o_ready && (flush || (model_pending && pair_jumps))) begin
      $display("[ERROR] %0t: o_ready high during a flush or a second jump", $time);
      errors++;
    end
    if (!o_ready) ready_dropped = 1'b1;
    if (!o_ready && model_pending && pair_jumps) stalls++;
    held = i_instr[0].valid && !o_ready;
    if (i_instr[0].valid && o_ready) begin
      for (int s = 0; s < 2; s++) begin
        if (i_instr[s].valid) begin
          e            = '0;
          e.index      = next_index;
          e.address    = i_instr[s].address;
          e.rd         = i_instr[s].rd;
          e.writes     = i_instr[s].flags.writes;
          e.jumps      = i_instr[s].flags.jumps;
          e.tag        = model_pending || (s == 1 && i_instr[0].flags.jumps);
          e.accept_cyc = 32'(cyc);
          model_q.push_back(e);
          next_index   = next_index + 1'b1;
        end
      end
      if (pair_jumps) model_pending = 1'b1;
      accepted++;
    end
  endtask

  task automatic run_cycles(int n, int issue_pct, int jump_pct, int result_pct, int mode);
    repeat (n) begin
      @(posedge cs);
      #2;
      drive_pair(issue_pct, jump_pct);
      drive_results(result_pct, mode);
      @(negedge cs);
      check_cycle();
    end
  endtask

  task automatic drain(int mode);
    int waited;
    waited = 0;
    while (model_q.size() > 0 && waited < DRAIN_LIMIT) begin
      run_cycles(1, 0, 0, 100, mode);
      waited++;
    end
    if (model_q.size() > 0) begin
      $display("%0d instructions never committed after all results were given", model_q.size());
      errors++;
    end
    // Quiet tail where nothing may commit
    run_cycles(5, 0, 0, 0, mode);
  endtask

  task automatic report(int num, string name, int errors_before);
    if (errors == errors_before) begin
      $display("Test %0d %s passed", num, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s failed with %0d errors", num, name, errors - errors_before);
    end
  endtask

  initial begin
    void'($urandom(32'hf9f0));
    i_reset  = 1'b1;
    i_instr  = '0;
    i_result = '0;
    repeat (RESET_CYCLES) @(posedge cs);
    #2;
    i_reset = 1'b0;

    mark = errors;
    run_cycles(20, 0, 0, 0, 0);
    if (!o_ready) begin
      $display("o_ready did not go high after reset");
      errors++;
    end
    report(1, "reset", mark);

    mark = errors;
    run_cycles(600, 70, 0, 60, 0);
    drain(0);
    report(2, "random dispatch", mark);

    mark = errors;
    ready_dropped = 1'b0;
    run_cycles(200, 100, 0, 0, 0);
    if (!ready_dropped) begin
      $display("o_ready never dropped while results were withheld");
      errors++;
    end
    stalls = accepted;
    run_cycles(100, 100, 0, 80, 0);
    if (accepted == stalls) begin
      $display("Dispatch did not resume after commits");
      errors++;
    end
    drain(0);
    report(3, "buffer full", mark);

    mark = errors;
    run_cycles(400, 70, 25, 60, 1);
    drain(1);
    report(4, "jump fall-through", mark);

    mark = errors;
    redirects = 0;
    run_cycles(400, 70, 25, 60, 2);
    drain(2);
    if (redirects == 0) begin
      $display("No redirect was seen for mispredicted jumps");
      errors++;
    end
    report(5, "jump redirect", mark);

    mark = errors;
    stalls = 0;
    run_cycles(400, 80, 60, 40, 0);
    drain(0);
    if (stalls == 0) begin
      $display("No pair was held back by a second jump");
      errors++;
    end
    report(6, "second jump stall", mark);

    $display("Summary: 6 tests, %0d failed, %0d commits, %0d errors", tests_failed, commits,
             errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
